//--- common/kr580_config.svh
`ifndef KR580_CONFIG_SVH
`define KR580_CONFIG_SVH

// Bus widths of the core
`define KR_DATA_W       8                   // Data bus and register width
`define KR_ADDR_W       16                  // Address bus and PC width

// Program counter after reset
`define KR_RESET_PC     16'h0000

// Flag register layout, 8080 style
//   7   6   5   4   3   2   1   0
//   S   Z   0   A   0   P   1   C
`define KR_FLAG_C       0                   // Carry or borrow
`define KR_FLAG_P       2                   // Parity or overflow
`define KR_FLAG_A       4                   // Half carry
`define KR_FLAG_Z       6                   // Zero
`define KR_FLAG_S       7                   // Sign

`endif

//--- common/kr580_pkg.sv
`default_nettype none

package kr580_pkg;

    // ALU operation, same order as opcode bits 5..3 of the ALU group
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_mode_t;

    // Register code as found in the y and z opcode fields
    typedef enum logic [2:0] {
        REG_B = 3'd0,
        REG_C = 3'd1,
        REG_D = 3'd2,
        REG_E = 3'd3,
        REG_H = 3'd4,
        REG_L = 3'd5,
        REG_M = 3'd6,                       // (HL) operand, not supported
        REG_A = 3'd7
    } reg_code_t;

    // Opcode seen as group, destination and source fields
    typedef struct packed {
        logic [1:0] grp;
        logic [2:0] y;                      // Destination reg or ALU mode
        logic [2:0] z;                      // Source reg or sub-opcode
    } op_reg_t;

    // Opcode seen as group, register pair and q bit
    typedef struct packed {
        logic [1:0] grp;
        logic [1:0] p;                      // BC, DE, HL, SP
        logic       q;
        logic [2:0] z;
    } op_pair_t;

    // One opcode byte, decoded through both views
    typedef union packed {
        op_reg_t  by_reg;
        op_pair_t by_pair;
    } opcode_u;

endpackage

`default_nettype wire

//--- common/kr580_rf_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_config.svh"

interface kr580_rf_if;
    import kr580_pkg::*;

    reg_code_t                rd_sel;       // Register read port select
    logic                     wr8_en;       // Single register write
    logic                     wr16_en;      // Pair write, wr_sel names the high half
    reg_code_t                wr_sel;
    logic [2*`KR_DATA_W-1:0]  wr_data;
    logic                     flags_we;
    logic [`KR_DATA_W-1:0]    flags_wdata;
    logic [`KR_DATA_W-1:0]    rd_data8;
    logic [`KR_DATA_W-1:0]    acc;
    logic [`KR_DATA_W-1:0]    flags;

    modport sequencer (
        output rd_sel, wr8_en, wr16_en, wr_sel, wr_data, flags_we, flags_wdata,
        input  rd_data8, acc, flags
    );

    modport regfile (
        input  rd_sel, wr8_en, wr16_en, wr_sel, wr_data, flags_we, flags_wdata,
        output rd_data8, acc, flags
    );

endinterface

`default_nettype wire

//--- cpu/kr580_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_config.svh"

module kr580_alu (
    input  wire kr580_pkg::alu_mode_t   mode_i,
    input  wire  [`KR_DATA_W-1:0]       op1_i,
    input  wire  [`KR_DATA_W-1:0]       op2_i,
    input  wire                         carry_i,
    output logic [`KR_DATA_W-1:0]       result_o,
    output logic [`KR_DATA_W-1:0]       flags_o
);
    import kr580_pkg::*;

    logic                   cin;
    logic [`KR_DATA_W:0]    sum;            // Ninth bit is carry or borrow
    logic [4:0]             half;           // Low nibble with its carry
    logic                   ovf;
    logic                   use_ovf;
    logic                   parity_even;

    // Only ADC and SBC take the stored carry
    assign cin = ((mode_i == ALU_ADC) || (mode_i == ALU_SBC)) ? carry_i : 1'b0;

    always_comb begin
        half = 5'd0;
        ovf  = 1'b0;
        case (mode_i)
            ALU_ADD, ALU_ADC: begin
                sum  = {1'b0, op1_i} + {1'b0, op2_i} + cin;
                half = {1'b0, op1_i[3:0]} + {1'b0, op2_i[3:0]} + cin;
                ovf  = (op1_i[`KR_DATA_W-1] == op2_i[`KR_DATA_W-1]) &&
                       (sum[`KR_DATA_W-1] != op1_i[`KR_DATA_W-1]);
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                sum  = {1'b0, op1_i} - {1'b0, op2_i} - cin;
                half = {1'b0, op1_i[3:0]} - {1'b0, op2_i[3:0]} - cin;
                ovf  = (op1_i[`KR_DATA_W-1] != op2_i[`KR_DATA_W-1]) &&
                       (sum[`KR_DATA_W-1] != op1_i[`KR_DATA_W-1]);
            end
            ALU_AND: sum = {1'b0, op1_i & op2_i};
            ALU_XOR: sum = {1'b0, op1_i ^ op2_i};
            ALU_OR:  sum = {1'b0, op1_i | op2_i};
            default: sum = '0;
        endcase
    end

    assign parity_even = ~^sum[`KR_DATA_W-1:0];
    assign use_ovf     = mode_i inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC};   // CP shows parity

    assign result_o = sum[`KR_DATA_W-1:0];

    always_comb begin
        flags_o = 8'b0000_0010;                                   // Bit 1 always set
        flags_o[`KR_FLAG_S] = sum[`KR_DATA_W-1];
        flags_o[`KR_FLAG_Z] = (sum[`KR_DATA_W-1:0] == '0);
        flags_o[`KR_FLAG_A] = half[4];                            // Zero for logic ops
        flags_o[`KR_FLAG_P] = use_ovf ? ovf : parity_even;
        flags_o[`KR_FLAG_C] = sum[`KR_DATA_W];
    end

endmodule

`default_nettype wire

//--- cpu/kr580_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_config.svh"

module kr580_regfile (
    input  wire             pin_clk,
    input  wire             reset_i,
    kr580_rf_if.regfile     rf
);
    import kr580_pkg::*;

    logic [`KR_DATA_W-1:0] b_q, c_q, d_q, e_q, h_q, l_q, a_q, f_q;

    // Combinational read port
    always_comb begin
        case (rf.rd_sel)
            REG_B:   rf.rd_data8 = b_q;
            REG_C:   rf.rd_data8 = c_q;
            REG_D:   rf.rd_data8 = d_q;
            REG_E:   rf.rd_data8 = e_q;
            REG_H:   rf.rd_data8 = h_q;
            REG_L:   rf.rd_data8 = l_q;
            REG_A:   rf.rd_data8 = a_q;
            default: rf.rd_data8 = '0;                            // No (HL) operand
        endcase
    end

    assign rf.acc   = a_q;
    assign rf.flags = f_q;

    always_ff @(posedge pin_clk) begin
        if (reset_i) begin
            b_q <= '0;
            c_q <= '0;
            d_q <= '0;
            e_q <= '0;
            h_q <= '0;
            l_q <= '0;
            a_q <= '0;
            f_q <= '0;
        end else begin
            if (rf.wr16_en) begin
                case (rf.wr_sel)                                  // High half names the pair
                    REG_B:   {b_q, c_q} <= rf.wr_data;
                    REG_D:   {d_q, e_q} <= rf.wr_data;
                    REG_H:   {h_q, l_q} <= rf.wr_data;
                    default: ;
                endcase
            end else if (rf.wr8_en) begin
                case (rf.wr_sel)
                    REG_B:   b_q <= rf.wr_data[`KR_DATA_W-1:0];
                    REG_C:   c_q <= rf.wr_data[`KR_DATA_W-1:0];
                    REG_D:   d_q <= rf.wr_data[`KR_DATA_W-1:0];
                    REG_E:   e_q <= rf.wr_data[`KR_DATA_W-1:0];
                    REG_H:   h_q <= rf.wr_data[`KR_DATA_W-1:0];
                    REG_L:   l_q <= rf.wr_data[`KR_DATA_W-1:0];
                    REG_A:   a_q <= rf.wr_data[`KR_DATA_W-1:0];
                    default: ;
                endcase
            end
            if (rf.flags_we) f_q <= rf.flags_wdata;
        end
    end

endmodule

`default_nettype wire

//--- cpu/kr580_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_config.svh"

module kr580_sequencer (
    input  wire                         pin_clk,
    input  wire                         reset_i,
    output logic [`KR_ADDR_W-1:0]       mem_addr_o,
    input  wire  [`KR_DATA_W-1:0]       mem_rdata_i,
    output logic [`KR_DATA_W-1:0]       mem_wdata_o,
    output logic                        mem_we_o,
    output logic [`KR_DATA_W-1:0]       port_addr_o,
    input  wire  [`KR_DATA_W-1:0]       port_rdata_i,
    output logic [`KR_DATA_W-1:0]       port_wdata_o,
    output logic                        port_we_o,
    output kr580_pkg::alu_mode_t        alu_mode_o,
    output logic [`KR_DATA_W-1:0]       alu_op1_o,
    output logic [`KR_DATA_W-1:0]       alu_op2_o,
    input  wire  [`KR_DATA_W-1:0]       alu_result_i,
    input  wire  [`KR_DATA_W-1:0]       alu_flags_i,
    kr580_rf_if.sequencer               rf
);
    import kr580_pkg::*;

    logic [1:0]             t_q;            // T-state within the instruction
    logic [`KR_ADDR_W-1:0]  pc_q;
    logic [`KR_ADDR_W-1:0]  cursor_q;       // Data address for LD (nn)
    logic                   alt_q;          // Put cursor on the address bus
    logic [`KR_DATA_W-1:0]  imm_lo_q;
    logic [`KR_DATA_W-1:0]  imm_hi_q;
    opcode_u                opcode_q;
    opcode_u                op;             // Opcode being decoded this cycle

    logic is_halt;
    logic is_ld_r_i8;
    logic is_ld_r_r;
    logic is_ld_rp;
    logic is_inc_dec;
    logic is_alu_r;
    logic is_alu_i;
    logic is_jp;
    logic is_st_a;
    logic is_ld_a;
    logic is_out;
    logic is_in;
    logic cc_flag;
    logic jp_taken;

    // In T0 the opcode is still on the data bus
    assign op = (t_q == 2'd0) ? mem_rdata_i : opcode_q;

    assign is_halt    = (op == 8'h76);
    assign is_ld_r_i8 = (op.by_reg.grp == 2'b00) && (op.by_reg.z == 3'd6) &&
                        (op.by_reg.y != REG_M);
    assign is_ld_r_r  = (op.by_reg.grp == 2'b01) && (op.by_reg.y != REG_M) &&
                        (op.by_reg.z != REG_M);
    assign is_ld_rp   = (op.by_pair.grp == 2'b00) && (op.by_pair.z == 3'd1) &&
                        !op.by_pair.q && (op.by_pair.p != 2'd3);  // No SP here
    assign is_inc_dec = (op.by_reg.grp == 2'b00) && (op.by_reg.z[2:1] == 2'b10) &&
                        (op.by_reg.y != REG_M);
    assign is_alu_r   = (op.by_reg.grp == 2'b10) && (op.by_reg.z != REG_M);
    assign is_alu_i   = (op.by_reg.grp == 2'b11) && (op.by_reg.z == 3'd6);
    assign is_jp      = (op == 8'hC3) || ((op.by_reg.grp == 2'b11) && (op.by_reg.z == 3'd2));
    assign is_st_a    = (op == 8'h32);
    assign is_ld_a    = (op == 8'h3A);
    assign is_out     = (op == 8'hD3);
    assign is_in      = (op == 8'hDB);

    // INC and DEC borrow ADD and SUB, z[0] tells them apart
    assign alu_mode_o = is_inc_dec ? (op.by_reg.z[0] ? ALU_SUB : ALU_ADD)
                                   : alu_mode_t'(op.by_reg.y);

    assign mem_addr_o = alt_q ? cursor_q : pc_q;

    // Condition code: y[2:1] picks Z/C/P/S, y[0] the wanted value
    always_comb begin
        case (op.by_reg.y[2:1])
            2'd0:    cc_flag = rf.flags[`KR_FLAG_Z];
            2'd1:    cc_flag = rf.flags[`KR_FLAG_C];
            2'd2:    cc_flag = rf.flags[`KR_FLAG_P];
            default: cc_flag = rf.flags[`KR_FLAG_S];
        endcase
        jp_taken = (op == 8'hC3) || (cc_flag == op.by_reg.y[0]);
    end

    // Register file requests, taken at the end of the current cycle
    always_comb begin
        rf.rd_sel      = is_inc_dec ? reg_code_t'(op.by_reg.y) : reg_code_t'(op.by_reg.z);
        rf.wr8_en      = 1'b0;
        rf.wr16_en     = 1'b0;
        rf.wr_sel      = reg_code_t'(op.by_reg.y);
        rf.wr_data     = {{`KR_DATA_W{1'b0}}, mem_rdata_i};
        rf.flags_we    = 1'b0;
        rf.flags_wdata = alu_flags_i;
        case (t_q)
            2'd1: begin
                if (is_ld_r_i8) rf.wr8_en = 1'b1;
                if (is_ld_r_r) begin
                    rf.wr8_en  = 1'b1;
                    rf.wr_data = {{`KR_DATA_W{1'b0}}, rf.rd_data8};
                end
            end
            2'd2: begin
                if (is_ld_rp) begin
                    rf.wr16_en = 1'b1;
                    rf.wr_sel  = reg_code_t'({op.by_pair.p, 1'b0});   // B, D or H
                    rf.wr_data = {mem_rdata_i, imm_lo_q};
                end
                if (is_inc_dec || is_alu_r || is_alu_i) begin
                    rf.wr8_en   = (alu_mode_o != ALU_CP);         // CP keeps A
                    rf.wr_sel   = is_inc_dec ? reg_code_t'(op.by_reg.y) : REG_A;
                    rf.wr_data  = {{`KR_DATA_W{1'b0}}, alu_result_i};
                    rf.flags_we = 1'b1;
                end
                if (is_in) begin
                    rf.wr8_en  = 1'b1;
                    rf.wr_sel  = REG_A;
                    rf.wr_data = {{`KR_DATA_W{1'b0}}, port_rdata_i};
                end
            end
            2'd3: begin
                if (is_ld_a) begin
                    rf.wr8_en = 1'b1;
                    rf.wr_sel = REG_A;                            // Data from cursor
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge pin_clk) begin
        if (reset_i) begin
            t_q       <= 2'd0;
            pc_q      <= `KR_RESET_PC;
            alt_q     <= 1'b0;
            mem_we_o  <= 1'b0;
            port_we_o <= 1'b0;
        end else begin
            alt_q     <= 1'b0;                                    // Strobes last one cycle
            mem_we_o  <= 1'b0;
            port_we_o <= 1'b0;
            if (t_q == 2'd0) opcode_q <= mem_rdata_i;

            if (is_halt) begin
                t_q <= 2'd0;                                      // Refetch at the same PC
            end else if (is_ld_r_i8 || is_ld_r_r) begin
                if (t_q == 2'd0 || is_ld_r_i8) pc_q <= pc_q + 1'b1;
                t_q <= (t_q == 2'd0) ? 2'd1 : 2'd0;
            end else if (is_ld_rp) begin
                pc_q     <= pc_q + 1'b1;
                imm_lo_q <= mem_rdata_i;
                t_q      <= (t_q == 2'd2) ? 2'd0 : t_q + 1'b1;
            end else if (is_inc_dec || is_alu_r || is_alu_i) begin
                case (t_q)
                    2'd0: begin
                        pc_q <= pc_q + 1'b1;
                        t_q  <= 2'd1;
                    end
                    2'd1: begin
                        alu_op1_o <= is_inc_dec ? rf.rd_data8 : rf.acc;
                        if (is_inc_dec) alu_op2_o <= {{(`KR_DATA_W-1){1'b0}}, 1'b1};
                        else if (is_alu_i) alu_op2_o <= mem_rdata_i;
                        else alu_op2_o <= rf.rd_data8;
                        if (is_alu_i) pc_q <= pc_q + 1'b1;        // Skip the immediate
                        t_q <= 2'd2;
                    end
                    default: t_q <= 2'd0;
                endcase
            end else if (is_jp || is_st_a || is_ld_a) begin
                case (t_q)
                    2'd0: pc_q <= pc_q + 1'b1;
                    2'd1: begin
                        pc_q     <= pc_q + 1'b1;
                        imm_lo_q <= mem_rdata_i;
                    end
                    2'd2: begin
                        pc_q     <= pc_q + 1'b1;
                        imm_hi_q <= mem_rdata_i;
                        cursor_q <= {mem_rdata_i, imm_lo_q};
                        alt_q    <= !is_jp;
                        mem_we_o <= is_st_a;
                        mem_wdata_o <= rf.acc;
                    end
                    default: if (is_jp && jp_taken) pc_q <= {imm_hi_q, imm_lo_q};
                endcase
                t_q <= t_q + 1'b1;                                // Wraps to T0 after T3
            end else if (is_out || is_in) begin
                if (t_q != 2'd2) pc_q <= pc_q + 1'b1;
                if (t_q == 2'd1) begin
                    port_addr_o  <= mem_rdata_i;
                    port_wdata_o <= rf.acc;
                    port_we_o    <= is_out;
                end
                t_q <= (t_q == 2'd0 || (is_in && t_q == 2'd1)) ? t_q + 1'b1 : 2'd0;
            end else begin
                pc_q <= pc_q + 1'b1;                              // Unsupported, one-cycle NOP
                t_q  <= 2'd0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/kr580_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_config.svh"

module kr580_top (
    input  wire                     pin_clk,
    input  wire                     reset_i,
    output logic [`KR_ADDR_W-1:0]   mem_addr_o,
    input  wire  [`KR_DATA_W-1:0]   mem_rdata_i,
    output logic [`KR_DATA_W-1:0]   mem_wdata_o,
    output logic                    mem_we_o,
    output logic [`KR_DATA_W-1:0]   port_addr_o,
    input  wire  [`KR_DATA_W-1:0]   port_rdata_i,
    output logic [`KR_DATA_W-1:0]   port_wdata_o,
    output logic                    port_we_o
);
    import kr580_pkg::*;

    alu_mode_t              alu_mode;
    logic [`KR_DATA_W-1:0]  alu_op1;
    logic [`KR_DATA_W-1:0]  alu_op2;
    logic [`KR_DATA_W-1:0]  alu_result;
    logic [`KR_DATA_W-1:0]  alu_flags;

    kr580_rf_if rf_bus ();

    kr580_sequencer u_seq (
        .pin_clk      (pin_clk),
        .reset_i      (reset_i),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we_o),
        .port_addr_o  (port_addr_o),
        .port_rdata_i (port_rdata_i),
        .port_wdata_o (port_wdata_o),
        .port_we_o    (port_we_o),
        .alu_mode_o   (alu_mode),
        .alu_op1_o    (alu_op1),
        .alu_op2_o    (alu_op2),
        .alu_result_i (alu_result),
        .alu_flags_i  (alu_flags),
        .rf           (rf_bus.sequencer)
    );

    kr580_alu u_alu (
        .mode_i   (alu_mode),
        .op1_i    (alu_op1),
        .op2_i    (alu_op2),
        .carry_i  (rf_bus.flags[`KR_FLAG_C]),                     // Stored carry for ADC/SBC
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    kr580_regfile u_rf (
        .pin_clk (pin_clk),
        .reset_i (reset_i),
        .rf      (rf_bus.regfile)
    );

endmodule

`default_nettype wire

//--- verif/kr580_tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_config.svh"

module kr580_tb_memory (
    input  wire                     pin_clk,
    input  wire  [`KR_ADDR_W-1:0]   addr_i,
    output logic [`KR_DATA_W-1:0]   rdata_o,
    input  wire  [`KR_DATA_W-1:0]   wdata_i,
    input  wire                     we_i
);

    logic [`KR_DATA_W-1:0] mem [0:(1<<`KR_ADDR_W)-1];

    // Background pattern mixes both address bytes
    initial begin
        for (int i = 0; i < (1 << `KR_ADDR_W); i++) begin
            mem[i] = (i[15:8] * 8'd7) ^ i[7:0] ^ 8'h3C;
        end
    end

    assign rdata_o = mem[addr_i];                       // Same-cycle read

    always @(posedge pin_clk) begin
        if (we_i) mem[addr_i] <= wdata_i;
    end

    // Program image loader, called before reset is released
    task automatic load_byte(input logic [`KR_ADDR_W-1:0] addr, input logic [7:0] data);
        mem[addr] = data;
    endtask

endmodule

`default_nettype wire

//--- verif/tb_kr580.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kr580;

    logic        pin_clk;
    logic        reset_i;
    logic [15:0] mem_addr;
    logic [7:0]  mem_rdata;
    logic [7:0]  mem_wdata;
    logic        mem_we;
    logic [7:0]  port_addr;
    logic [7:0]  port_rdata;
    logic [7:0]  port_wdata;
    logic        port_we;

    logic [7:0]  prog [0:4095];
    int          prog_len = 0;
    int          instr_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          halt_addr;
    logic [7:0]  rm [0:7];                              // Register model indexed by register code
    logic [7:0]  fm;                                    // Flag model
    logic [7:0]  in_table [0:255];
    logic [7:0]  store_val;
    string       cur_test;
    int          regs [0:6] = '{0, 1, 2, 3, 4, 5, 7};

    logic        exp_is_mem [$];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    string       exp_name [$];

    kr580_top UUT (
        .pin_clk      (pin_clk),
        .reset_i      (reset_i),
        .mem_addr_o   (mem_addr),
        .mem_rdata_i  (mem_rdata),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .port_addr_o  (port_addr),
        .port_rdata_i (port_rdata),
        .port_wdata_o (port_wdata),
        .port_we_o    (port_we)
    );

    kr580_tb_memory u_mem (
        .pin_clk (pin_clk),
        .addr_i  (mem_addr),
        .rdata_o (mem_rdata),
        .wdata_i (mem_wdata),
        .we_i    (mem_we)
    );

    initial begin
        pin_clk = 1'b0;
        forever #10 pin_clk = ~pin_clk;
    end

    // Reference ALU on integers with the flag byte in 8080 order
    function automatic logic [15:0] alu_ref(input int mode, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
        int x, y, c, r9, lo, sa, sb, sr;
        logic hc, ov, p;
        logic [7:0] res;
        x = a;
        y = b;
        c = (mode == 1 || mode == 3) ? cin : 0;
        sa = (x > 127) ? x - 256 : x;
        sb = (y > 127) ? y - 256 : y;
        hc = 1'b0;
        sr = 0;
        case (mode)
            0, 1: begin
                r9 = x + y + c;
                lo = (x % 16) + (y % 16) + c;
                hc = (lo > 15);
                sr = sa + sb + c;
            end
            2, 3, 7: begin
                r9 = x - y - c;
                lo = (x % 16) - (y % 16) - c;
                hc = (lo < 0);
                sr = sa - sb - c;
            end
            4: r9 = x & y;
            5: r9 = x ^ y;
            default: r9 = x | y;
        endcase
        res = r9[7:0];
        ov = (sr > 127) || (sr < -128);
        p = (mode <= 3) ? ov : ~^res;
        return {res[7], res == 8'h00, 1'b0, hc, 1'b0, p, 1'b1, (r9 > 255) || (r9 < 0),
                res};
    endfunction

    task automatic put_byte(input logic [7:0] b);
        prog[prog_len] = b;
        prog_len++;
    endtask

    task automatic expect_write(input logic is_mem, input logic [15:0] a,
                                input logic [7:0] d, input string name);
        exp_is_mem.push_back(is_mem);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_name.push_back(name);
    endtask

    task automatic load_immediate(input int r, input logic [7:0] v);
        put_byte({2'b00, r[2:0], 3'b110});
        put_byte(v);
        rm[r] = v;
        instr_cnt++;
    endtask

    task automatic move_register(input int d, input int s);
        put_byte({2'b01, d[2:0], s[2:0]});
        rm[d] = rm[s];
        instr_cnt++;
    endtask

    task automatic load_pair(input int p, input logic [15:0] v);
        put_byte({2'b00, p[1:0], 4'b0001});
        put_byte(v[7:0]);
        put_byte(v[15:8]);
        rm[2*p]     = v[15:8];
        rm[2*p + 1] = v[7:0];
        instr_cnt++;
    endtask

    task automatic alu_instruction(input int mode, input int s, input logic use_imm,
                                   input logic [7:0] v);
        logic [15:0] r;
        if (use_imm) begin
            put_byte({2'b11, mode[2:0], 3'b110});
            put_byte(v);
            r = alu_ref(mode, rm[7], v, fm[0]);
        end else begin
            put_byte({2'b10, mode[2:0], s[2:0]});
            r = alu_ref(mode, rm[7], rm[s], fm[0]);
        end
        if (mode != 7) rm[7] = r[7:0];                  // CP leaves A alone
        fm = r[15:8];
        instr_cnt++;
    endtask

    task automatic inc_dec_register(input int r, input logic dec);
        logic [15:0] res;
        put_byte({2'b00, r[2:0], 2'b10, dec});
        res = alu_ref(dec ? 2 : 0, rm[r], 8'h01, 1'b0);
        rm[r] = res[7:0];
        fm = res[15:8];
        instr_cnt++;
    endtask

    task automatic jump_to(input logic [7:0] opc, input int target);
        put_byte(opc);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
        instr_cnt++;
    endtask

    task automatic out_to_port(input logic [7:0] port);
        put_byte(8'hD3);
        put_byte(port);
        expect_write(1'b0, {8'h00, port}, rm[7], cur_test);
        instr_cnt++;
    endtask

    task automatic in_from_port(input logic [7:0] port);
        put_byte(8'hDB);
        put_byte(port);
        rm[7] = in_table[port];
        instr_cnt++;
    endtask

    task automatic store_or_load_acc(input logic [15:0] addr, input logic load);
        put_byte(load ? 8'h3A : 8'h32);
        put_byte(addr[7:0]);
        put_byte(addr[15:8]);
        if (load) begin
            rm[7] = store_val;
        end else begin
            store_val = rm[7];
            expect_write(1'b1, addr, rm[7], cur_test);
        end
        instr_cnt++;
    endtask

    // JP Z, JP C, JP PE and JP M each jump to a block that writes its own marker
    task automatic flag_branches();
        logic taken;
        int start;
        for (int k = 0; k < 4; k++) begin
            case (k)
                0: taken = fm[6];
                1: taken = fm[0];
                2: taken = fm[2];
                default: taken = fm[7];
            endcase
            start = prog_len;
            jump_to(8'hCA + 8'h10 * k, start + 6);
            jump_to(8'hC3, start + 10);                 // Skip the block
            put_byte(8'h3E);
            put_byte(8'hA0 + k);
            put_byte(8'hD3);
            put_byte(8'hE0 + k);
            instr_cnt += 2;
            if (taken) begin
                rm[7] = 8'hA0 + k;
                expect_write(1'b0, 16'h00E0 + k, 8'hA0 + k,
                             $sformatf("%s branch %0d", cur_test, k));
            end
        end
    endtask

    task automatic alu_case(input int mode, input logic [7:0] a, input logic [7:0] b,
                            input logic use_imm);
        int s;
        s = regs[$urandom % 6];
        cur_test = $sformatf("alu mode %0d %s", mode, use_imm ? "imm" : "reg");
        load_immediate(7, a);
        if (!use_imm) load_immediate(s, b);
        alu_instruction(mode, s, use_imm, b);
        out_to_port(8'h10 + mode);
        flag_branches();
    endtask

    task automatic build_program();
        logic [7:0]  v;
        logic [15:0] addr;
        for (int m = 0; m < 8; m++) begin
            alu_case(m, $urandom, $urandom, 1'b0);
            alu_case(m, $urandom, $urandom, 1'b1);
        end
        v = $urandom;
        alu_case(2, v, v, 1'b0);                        // Zero result
        alu_case(0, 8'h80, 8'h80, 1'b1);                // Carry and overflow
        alu_case(7, v, v, 1'b1);
        cur_test = "ld r,r";
        for (int si = 0; si < 7; si++) begin
            for (int di = 0; di < 7; di++) begin
                load_immediate(regs[si], $urandom);
                move_register(regs[di], regs[si]);
                move_register(7, regs[di]);
                out_to_port(8'h20);
            end
        end
        cur_test = "ld rp";
        for (int p = 0; p < 3; p++) begin
            load_pair(p, $urandom);
            move_register(7, 2 * p);
            out_to_port(8'h21);
            move_register(7, 2 * p + 1);
            out_to_port(8'h21);
        end
        put_byte(8'h31);                                // Pair code 3 runs as NOP
        instr_cnt++;
        out_to_port(8'h21);
        for (int i = 0; i < 7; i++) begin
            cur_test = $sformatf("inc reg %0d", regs[i]);
            load_immediate(regs[i], 8'hFF);
            inc_dec_register(regs[i], 1'b0);
            move_register(7, regs[i]);
            out_to_port(8'h22);
            flag_branches();
            cur_test = $sformatf("dec reg %0d", regs[i]);
            load_immediate(regs[i], 8'h00);
            inc_dec_register(regs[i], 1'b1);
            move_register(7, regs[i]);
            out_to_port(8'h22);
            flag_branches();
        end
        cur_test = "store load";
        addr = 16'h8000 | ($urandom & 16'h7FFF);
        v = $urandom;
        load_immediate(7, v);
        store_or_load_acc(addr, 1'b0);
        load_immediate(7, ~v);
        store_or_load_acc(addr, 1'b1);
        out_to_port(8'h30);
        cur_test = "port in";
        in_from_port($urandom);
        out_to_port(8'h31);
        in_from_port($urandom);
        out_to_port(8'h31);
        halt_addr = prog_len;
        put_byte(8'h76);
        instr_cnt++;
    endtask

    task automatic check_write(input logic is_mem, input logic [15:0] a, input logic [7:0] d);
        string name;
        logic e_mem;
        logic [15:0] ea;
        logic [7:0] ed;
        assert (exp_addr.size() != 0) else begin
            other_cnt++;
            $display("Unexpected %s write at %h with data %h", is_mem ? "memory" : "port",
                     a, d);
        end
        if (exp_addr.size() != 0) begin
            e_mem = exp_is_mem.pop_front();
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            name = exp_name.pop_front();
            assert (e_mem == is_mem) else begin
                other_cnt++;
                $display("%s: a write went to the wrong bus", name);
            end
            assert (ea == a) else begin
                mismatch_cnt++;
                $display("MISMATCH %s address expected %h actual %h", name, ea, a);
            end
            assert (ed == d) else begin
                mismatch_cnt++;
                $display("MISMATCH %s data expected %h actual %h", name, ed, d);
            end
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    endtask

    // Write strobes are registered and settle before the falling edge
    always @(negedge pin_clk) begin
        if (!reset_i) begin
            if (port_we) check_write(1'b0, {8'h00, port_addr}, port_wdata);
            if (mem_we) check_write(1'b1, mem_addr, mem_wdata);
        end
    end

    // Port device answers for whatever address the core presents
    always @(negedge pin_clk) begin
        if (!$isunknown(port_addr)) port_rdata <= in_table[port_addr];
    end

    always @(posedge pin_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            other_cnt++;
            $display("Timeout after %0d cycles, the program never reached HALT", cycle_cnt);
            print_counts();
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] seed_val;
        reset_i = 1'b1;
        port_rdata = 8'h00;
        seed_val = $urandom(32'h811f_52e0);
        for (int i = 0; i < 8; i++) rm[i] = 8'h00;
        fm = 8'h00;
        for (int i = 0; i < 256; i++) in_table[i] = $urandom;
        build_program();
        cycle_limit = 4 * instr_cnt + 100;
        @(negedge pin_clk);
        for (int i = 0; i < prog_len; i++) u_mem.load_byte(i[15:0], prog[i]);
        @(posedge pin_clk);
        @(posedge pin_clk);
        @(negedge pin_clk);
        assert (mem_we === 1'b0 && port_we === 1'b0) else begin
            other_cnt++;
            $display("A write strobe is not low after reset");
        end
        assert (mem_addr === 16'h0000) else begin
            mismatch_cnt++;
            $display("MISMATCH reset address expected %h actual %h", 16'h0000, mem_addr);
        end
        reset_i = 1'b0;
        while (exp_addr.size() != 0 || mem_addr !== halt_addr[15:0]) @(negedge pin_clk);
        repeat (50) begin
            @(negedge pin_clk);
            assert (mem_addr === halt_addr[15:0]) else begin
                mismatch_cnt++;
                $display("MISMATCH halt address expected %h actual %h", halt_addr[15:0],
                         mem_addr);
            end
        end
        print_counts();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/kr580_pkg.sv
common/kr580_rf_if.sv
cpu/kr580_alu.sv
cpu/kr580_regfile.sv
cpu/kr580_sequencer.sv
hw/kr580_top.sv
verif/kr580_tb_memory.sv
verif/tb_kr580.sv
